/* HoldGenPkg.sv */
`default_nettype none

`include "HoldGen_defs.svh"

package HoldGenPkg;

    ////////////////////////////////////////////////////
    // Hold path types
    ////////////////////////////////////////////////////

    // Settings written over the bus
    typedef struct packed {
        logic                     holdEnable;
        logic [`HOLD_DELAY_W-1:0] holdDelay;
        logic [`HOLD_TIME_W-1:0]  holdTime;
    } holdConfig_t;

    // Live state reported back to the registers
    typedef struct packed {
        logic                    holdActive;
        logic [`HOLD_TIME_W-1:0] holdCount;
    } holdStatus_t;

    ////////////////////////////////////////////////////
    // Wishbone classic bundles
    ////////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_ADR_W-1:0] adr;
        logic [`WB_DAT_W-1:0] dat;
    } wbReq_t;

    // Slave to master, dat only meaningful with ack
    typedef struct packed {
        logic                 ack;
        logic [`WB_DAT_W-1:0] dat;
    } wbRsp_t;

endpackage

`default_nettype wire

/* HoldGenTop.sv */
`timescale 1ns/1ps
`default_nettype none

module HoldGenTop
    import HoldGenPkg::*;
(
    input  wire logic   Clk,
    input  wire logic   reset_n,
    input  wire logic   TrigIn,
    input  wire wbReq_t wbIn,
    output wbRsp_t      wbOut,
    output logic        HoldOut
);

    ////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////

    // Settings fan out to delay line and pulse generator
    holdConfig_t cfg;
    // Live window state back to the register block
    holdStatus_t status;
    logic        countClear;
    logic        trigDelayed;

    // Bus slave and settings
    HoldRegs HoldRegs_inst (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .wbIn       (wbIn),
        .wbOut      (wbOut),
        .status     (status),
        .cfg        (cfg),
        .countClear (countClear)
    );

    // Programmable trigger delay
    TrigDelayLine TrigDelayLine_inst (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .TrigIn      (TrigIn),
        .cfg         (cfg),
        .trigDelayed (trigDelayed)
    );

    // Window generation and count
    HoldPulseGen HoldPulseGen_inst (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .trigDelayed (trigDelayed),
        .cfg         (cfg),
        .countClear  (countClear),
        .status      (status),
        .HoldOut     (HoldOut)
    );

endmodule

`default_nettype wire

/* HoldGen_defs.svh */
`ifndef HOLDGEN_DEFS_SVH
`define HOLDGEN_DEFS_SVH

////////////////////////////////////////////////////
// Hold path sizing
////////////////////////////////////////////////////

// Stages in the trigger delay line
`define HOLD_DELAY_DEPTH 256
// Delay select width, log2 of the depth
`define HOLD_DELAY_W 8
// Window length and window counter width
`define HOLD_TIME_W 16

////////////////////////////////////////////////////
// Wishbone bus and register map
////////////////////////////////////////////////////

// Word address and data widths
`define WB_ADR_W 3
`define WB_DAT_W 32

`define REG_CTRL 3'd0
`define REG_DELAY 3'd1
`define REG_TIME 3'd2
`define REG_COUNT 3'd3
`define REG_STATUS 3'd4

`endif

/* HoldPulseGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "HoldGen_defs.svh"

module HoldPulseGen
    import HoldGenPkg::*;
(
    input  wire logic        Clk,
    input  wire logic        reset_n,
    input  wire logic        trigDelayed,
    input  wire holdConfig_t cfg,
    input  wire logic        countClear,
    output holdStatus_t      status,
    output logic             HoldOut
);

    ////////////////////////////////////////////////////
    // Edge detect
    ////////////////////////////////////////////////////

    logic                    trigQ;
    logic                    trigQ2;
    logic                    trigRise;
    logic                    windowStart;
    logic                    holdQ;
    logic [`HOLD_TIME_W-1:0] windowCnt;
    logic [`HOLD_TIME_W-1:0] holdCount;

    // Two flops, the first registers the tap output
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            trigQ  <= 1'b0;
            trigQ2 <= 1'b0;
        end else begin
            trigQ  <= trigDelayed;
            trigQ2 <= trigQ;
        end
    end

    assign trigRise = trigQ & ~trigQ2;

    // Open only when enabled, idle and the window is nonzero
    // Edges inside an open window are dropped here
    assign windowStart = trigRise & cfg.holdEnable & ~holdQ
                       & (cfg.holdTime != '0);

    ////////////////////////////////////////////////////
    // Hold window
    ////////////////////////////////////////////////////

    // Counter holds the cycles left after the current one
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            holdQ     <= 1'b0;
            windowCnt <= '0;
        end else if (windowStart) begin
            holdQ     <= 1'b1;
            windowCnt <= cfg.holdTime - 1'b1;
        end else if (holdQ) begin
            if (windowCnt == '0) begin
                // Last cycle of the window
                holdQ <= 1'b0;
            end else begin
                windowCnt <= windowCnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Window count
    ////////////////////////////////////////////////////

    // Saturating, clear wins over a same-cycle increment
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            holdCount <= '0;
        end else if (countClear) begin
            holdCount <= '0;
        end else if (windowStart && (holdCount != '1)) begin
            holdCount <= holdCount + 1'b1;
        end
    end

    // Outputs
    assign HoldOut = holdQ;
    assign status  = '{holdActive: holdQ, holdCount: holdCount};

endmodule

`default_nettype wire

/* HoldRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "HoldGen_defs.svh"

module HoldRegs
    import HoldGenPkg::*;
(
    input  wire logic        Clk,
    input  wire logic        reset_n,
    input  wire wbReq_t      wbIn,
    output wbRsp_t           wbOut,
    input  wire holdStatus_t status,
    output holdConfig_t      cfg,
    output logic             countClear
);

    ////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////

    logic                 ackQ;
    logic                 wbAccess;
    logic                 wbWrite;
    logic [`WB_DAT_W-1:0] rdMux;
    logic [`WB_DAT_W-1:0] rdData;
    holdConfig_t          cfgQ;

    // New access only while ack is low, so one ack per cycle
    assign wbAccess = wbIn.cyc & wbIn.stb & ~ackQ;
    assign wbWrite  = wbAccess & wbIn.we;

    // Ack one cycle after stb, high for exactly one cycle
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= wbAccess;
        end
    end

    ////////////////////////////////////////////////////
    // Writable settings
    ////////////////////////////////////////////////////

    // Write lands on the same edge that raises ack
    // Upper data bits beyond each field are dropped
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            cfgQ.holdEnable <= 1'b0;
            cfgQ.holdDelay  <= '0;
            cfgQ.holdTime   <= '0;
        end else if (wbWrite) begin
            case (wbIn.adr)
                `REG_CTRL: begin
                    cfgQ.holdEnable <= wbIn.dat[0];
                end
                `REG_DELAY: begin
                    cfgQ.holdDelay <= wbIn.dat[`HOLD_DELAY_W-1:0];
                end
                `REG_TIME: begin
                    cfgQ.holdTime <= wbIn.dat[`HOLD_TIME_W-1:0];
                end
                default: begin
                    // Read-only and unmapped words keep their state
                end
            endcase
        end
    end

    assign cfg = cfgQ;

    // Any write to the count word clears it on the ack edge
    assign countClear = wbWrite & (wbIn.adr == `REG_COUNT);

    ////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////

    // Unused bits and unmapped words read zero
    always_comb begin
        rdMux = '0;
        case (wbIn.adr)
            `REG_CTRL: begin
                rdMux[0] = cfgQ.holdEnable;
            end
            `REG_DELAY: begin
                rdMux[`HOLD_DELAY_W-1:0] = cfgQ.holdDelay;
            end
            `REG_TIME: begin
                rdMux[`HOLD_TIME_W-1:0] = cfgQ.holdTime;
            end
            `REG_COUNT: begin
                rdMux[`HOLD_TIME_W-1:0] = status.holdCount;
            end
            `REG_STATUS: begin
                rdMux[0] = status.holdActive;
            end
            default: begin
                rdMux = '0;
            end
        endcase
    end

    // Captured with the access, valid while ack is high
    always_ff @(posedge Clk) begin
        if (wbAccess) begin
            rdData <= rdMux;
        end
    end

    assign wbOut = '{ack: ackQ, dat: rdData};

endmodule

`default_nettype wire

/* Makefile */
TOP = tb_HoldGen

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* TrigDelayLine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "HoldGen_defs.svh"

module TrigDelayLine
    import HoldGenPkg::*;
(
    input  wire logic        Clk,
    input  wire logic        reset_n,
    input  wire logic        TrigIn,
    input  wire holdConfig_t cfg,
    output logic             trigDelayed
);

    ////////////////////////////////////////////////////
    // Shift register
    ////////////////////////////////////////////////////

    // One bit per Clk period of delay
    logic [`HOLD_DELAY_DEPTH-1:0] trigShift;

    // Stage 0 holds TrigIn as sampled on the last edge
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            // Drops any trigger still travelling down the line
            trigShift <= '0;
        end else begin
            trigShift <= {trigShift[`HOLD_DELAY_DEPTH-2:0], TrigIn};
        end
    end

    ////////////////////////////////////////////////////
    // Tap select
    ////////////////////////////////////////////////////

    // Delay of d puts an edge-k sample out after edge k+d
    // A delay change moves the tap at once, so a trigger
    // in flight may be skipped or seen twice
    assign trigDelayed = trigShift[cfg.holdDelay];

endmodule

`default_nettype wire

/* src.f */
+incdir+.
HoldGenPkg.sv
TrigDelayLine.sv
HoldPulseGen.sv
HoldRegs.sv
HoldGenTop.sv
tb_HoldGen.sv

/* tb_HoldGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "HoldGen_defs.svh"

module tb_HoldGen
    import HoldGenPkg::*;
();

    localparam int TIMEOUT = 1000;

    logic   Clk;
    logic   reset_n;
    logic   TrigIn;
    wbReq_t wbIn;
    wbRsp_t wbOut;
    logic   HoldOut;

    // Bookkeeping
    string        testName;
    int           valueErrors;
    int           otherErrors;
    int           holdErrors;
    logic [31:0]  lfsrState;
    bit           holdAtAccess;
    int           countAtClear;

    // Model settings, changed only while the line is quiet
    bit           mEnable;
    int           mDelay;
    int           mTime;
    // Model state
    logic [259:0] trigHist;
    logic [8:0]   tapIdx;
    bit           modelHold;
    int           modelLeft;
    int           modelCount;

    HoldGenTop HoldGenTop_inst (
        .Clk     (Clk),
        .reset_n (reset_n),
        .TrigIn  (TrigIn),
        .wbIn    (wbIn),
        .wbOut   (wbOut),
        .HoldOut (HoldOut)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    ////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////

    // trigHist[j] is TrigIn as sampled j edges ago
    // Window opens delay+2 edges after the first high sample
    always @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            trigHist   = '0;
            modelHold  = 1'b0;
            modelLeft  = 0;
            modelCount = 0;
        end else begin
            trigHist = {trigHist[258:0], TrigIn};
            tapIdx   = 9'(mDelay + 2);
            if (modelHold) begin
                // Open window ignores any new edge
                modelLeft--;
                if (modelLeft == 0) begin
                    modelHold = 1'b0;
                end
            end else if (trigHist[tapIdx] && !trigHist[tapIdx + 9'd1] && mEnable
                         && mTime != 0) begin
                modelHold = 1'b1;
                modelLeft = mTime;
                if (modelCount < 65535) begin
                    modelCount++;
                end
            end
        end
    end

    // HoldOut follows the model on every cycle
    holdMatchesModel: assert property (@(negedge Clk) disable iff (!reset_n)
                                       HoldOut == modelHold)
        else begin
            holdErrors++;
            $display("error %s HoldOut: expected %0b, actual %0b", testName, modelHold, HoldOut);
        end

    ////////////////////////////////////////////////////
    // Checks and random numbers
    ////////////////////////////////////////////////////

    task automatic checkEqual(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected == actual)
            else begin
                valueErrors++;
                $display("error %s %s: expected 0x%0h, actual 0x%0h",
                         testName, what, expected, actual);
            end
    endtask

    task automatic checkTrue(input string what, input bit cond);
        assert (cond)
            else begin
                otherErrors++;
                $display("Failure in %s: %s", testName, what);
            end
    endtask

    task automatic printCounts();
        $display("Error counts: %0d value, %0d hold mismatch, %0d other",
                 valueErrors, holdErrors, otherErrors);
    endtask

    task automatic abortTimeout(input string what);
        otherErrors++;
        $display("Timeout in %s: %s did not happen within %0d cycles", testName, what, TIMEOUT);
        printCounts();
        $display("Finished with errors");
        $finish;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrShift(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] nextRandom(input int nbits);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsrState = lfsrShift(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    ////////////////////////////////////////////////////
    // Bus and trigger tasks
    ////////////////////////////////////////////////////

    // Called 1 ns after an edge, returns 1 ns after an edge
    task automatic busAccess(input logic we, input logic [2:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int waited;
        wbIn.cyc = 1'b1;
        wbIn.stb = 1'b1;
        wbIn.we  = we;
        wbIn.adr = adr;
        wbIn.dat = data;
        // Window state the slave captures with this access
        @(negedge Clk);
        holdAtAccess = modelHold;
        waited = 0;
        do begin
            @(posedge Clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                abortTimeout("Wishbone ack");
            end
        end while (!wbOut.ack);
        rdata = wbOut.dat;
        checkEqual("ack latency", 32'd1, waited);
        wbIn = '0;
        @(posedge Clk);
        #1;
        checkEqual("ack width", 32'd0, {31'b0, wbOut.ack});
    endtask

    task automatic busWrite(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, adr, data, unused);
    endtask

    task automatic checkRead(input string what, input logic [2:0] adr,
                             input logic [31:0] expected);
        logic [31:0] got;
        busAccess(1'b0, adr, 32'd0, got);
        checkEqual(what, expected, got);
    endtask

    task automatic checkCount();
        checkRead("count", `REG_COUNT, 32'(modelCount - countAtClear));
    endtask

    task automatic setConfig(input bit en, input int d, input int t);
        busWrite(`REG_CTRL, {31'b0, en});
        busWrite(`REG_DELAY, 32'(d));
        busWrite(`REG_TIME, 32'(t));
        mEnable = en;
        mDelay  = d;
        mTime   = t;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge Clk);
        #1;
    endtask

    task automatic waitHoldLow();
        int waited;
        waited = 0;
        while (HoldOut) begin
            @(posedge Clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                abortTimeout("HoldOut fall");
            end
        end
    endtask

    // Delay line empty and no window open
    task automatic waitQuiet();
        waitCycles(`HOLD_DELAY_DEPTH + 8);
        waitHoldLow();
    endtask

    // High for one sample, taken on the next edge
    task automatic pulseTrigger();
        TrigIn = 1'b1;
        @(posedge Clk);
        #1;
        TrigIn = 1'b0;
    endtask

    // Edges from the sampling edge to the rise, then window width
    task automatic measureHold(output int latency, output int width);
        latency = 0;
        while (!HoldOut) begin
            @(posedge Clk);
            #1;
            latency++;
            if (latency > TIMEOUT) begin
                abortTimeout("HoldOut rise");
            end
        end
        width = 0;
        while (HoldOut) begin
            @(posedge Clk);
            #1;
            width++;
            if (width > TIMEOUT) begin
                abortTimeout("HoldOut fall");
            end
        end
    endtask

    task automatic watchNoHold(input int n);
        repeat (n) begin
            @(posedge Clk);
            #1;
            checkEqual("HoldOut", 32'd0, {31'b0, HoldOut});
        end
    endtask

    ////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////

    initial begin
        int          i;
        int          d;
        int          t;
        int          lat;
        int          wid;
        int          gap;
        int          seenActive;
        int          seenIdle;
        logic [31:0] got;
        valueErrors  = 0;
        otherErrors  = 0;
        holdErrors   = 0;
        lfsrState    = 32'h33ef;
        countAtClear = 0;
        mEnable      = 1'b0;
        mDelay       = 0;
        mTime        = 0;
        testName     = "reset";
        reset_n      = 1'b0;
        TrigIn       = 1'b0;
        wbIn         = '0;
        repeat (10) @(posedge Clk);
        #1;
        reset_n = 1'b1;

        // Reset values, unmapped words read zero
        testName = "registers";
        for (i = 0; i < 8; i++) begin
            checkRead("reset value", 3'(i), 32'd0);
        end
        busWrite(`REG_CTRL, 32'hFFFF_FFFF);
        busWrite(`REG_DELAY, 32'hFFFF_FFA5);
        busWrite(`REG_TIME, 32'hABCD_1234);
        mEnable = 1'b1;
        mDelay  = 32'h0000_00A5;
        mTime   = 32'h0000_1234;
        for (i = 4; i < 8; i++) begin
            busWrite(3'(i), 32'hFFFF_FFFF);
        end
        checkRead("ctrl", `REG_CTRL, 32'h1);
        checkRead("delay", `REG_DELAY, 32'hA5);
        checkRead("time", `REG_TIME, 32'h1234);
        for (i = 4; i < 8; i++) begin
            checkRead("read-only or unmapped", 3'(i), 32'd0);
        end
        setConfig(1'b0, 0, 0);

        // Delay extremes first, then random
        testName = "delay";
        for (i = 0; i < 8; i++) begin
            d = (i == 0) ? 0 : (i == 1) ? 255 : int'(nextRandom(8));
            t = 1 + int'(nextRandom(4));
            waitQuiet();
            setConfig(1'b1, d, t);
            pulseTrigger();
            measureHold(lat, wid);
            checkEqual("latency", 32'(d + 2), 32'(lat));
        end
        waitQuiet();
        checkCount();

        testName = "window";
        for (i = 0; i < 6; i++) begin
            d = int'(nextRandom(3));
            t = 1 + int'(nextRandom(8));
            waitQuiet();
            setConfig(1'b1, d, t);
            pulseTrigger();
            measureHold(lat, wid);
            checkEqual("width", 32'(t), 32'(wid));
        end
        waitQuiet();
        checkCount();
        // Zero length opens nothing
        setConfig(1'b1, 2, 0);
        pulseTrigger();
        watchNoHold(20);
        checkCount();

        testName = "enable";
        waitQuiet();
        setConfig(1'b0, 4, 10);
        pulseTrigger();
        watchNoHold(20);
        checkCount();

        // Second edge lands 4 cycles into a 40 cycle window
        testName = "retrigger";
        waitQuiet();
        setConfig(1'b1, 3, 40);
        pulseTrigger();
        waitCycles(8);
        pulseTrigger();
        checkEqual("HoldOut", 32'd1, {31'b0, HoldOut});
        measureHold(lat, wid);
        checkEqual("remaining width", 32'(40 - (9 - (3 + 2))), 32'(wid));
        waitQuiet();
        checkCount();

        // Random train with status reads in the gaps
        testName   = "count";
        seenActive = 0;
        seenIdle   = 0;
        waitQuiet();
        setConfig(1'b1, int'(nextRandom(4)), 1 + int'(nextRandom(4)));
        for (i = 0; i < 40; i++) begin
            pulseTrigger();
            gap = 1 + int'(nextRandom(5));
            repeat (gap) begin
                if (nextRandom(1) != 32'd0) begin
                    busAccess(1'b0, `REG_STATUS, 32'd0, got);
                    checkEqual("status", {31'b0, holdAtAccess}, got);
                    if (holdAtAccess) begin
                        seenActive++;
                    end else begin
                        seenIdle++;
                    end
                end else begin
                    waitCycles(1);
                end
            end
        end
        waitQuiet();
        checkCount();
        checkTrue("status was never read during a window", seenActive > 0);
        checkTrue("status was never read outside a window", seenIdle > 0);
        // Any write clears
        busWrite(`REG_COUNT, 32'h5A5A_0001);
        countAtClear = modelCount;
        checkRead("count after clear", `REG_COUNT, 32'd0);
        // Counting resumes from zero
        pulseTrigger();
        waitQuiet();
        checkCount();

        printCounts();
        if (valueErrors + holdErrors + otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
